/* compile.f */
+incdir+design
design/cachePkg.sv
design/cacheIfs.sv
design/cacheTagStore.sv
design/cacheController.sv
design/cacheDataStore.sv
design/cacheTop.sv
testbench/cacheChecker.sv
testbench/cacheTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f compile.f --top-module cacheTb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/VcacheTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

/* testbench/cacheTb.sv */
`include "cache_params.svh"

module cacheTb import cachePkg::*; ();

	logic               clock;
	logic               arstN;
	logic               pStrobe;
	sysOp_t             pRw;
	logic [`ADDR_W-1:0] pAddr;
	logic [`DATA_W-1:0] pWData;
	logic [`DATA_W-1:0] pRData;
	logic               cReady;
	logic               sysStrobe;
	sysOp_t             sysRw;
	logic [`ADDR_W-1:0] sysAddr;
	logic [`DATA_W-1:0] sysWData;
	logic               sysWordValid;
	logic [`DATA_W-1:0] sysRData;
	logic [31:0]        lfsr;
	logic [`DATA_W-1:0] memory [2**`ADDR_W];
	logic               timedOut;

	cacheTop DUT (.*);

	cacheChecker check (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////
	// Random numbers
	////////////////////////////////////////

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return value;
	endfunction

	////////////////////////////////////////
	// System memory model
	////////////////////////////////////////

	initial begin
		logic [`ADDR_W-1:0] base;
		logic [31:0]        waits;
		for (int i = 0; i < 2**`ADDR_W; i++) begin
			memory[i] = {i[15:0], i[15:0] ^ 16'h5a3c};
		end
		forever begin
			@(negedge clock);
			if (arstN && sysStrobe && sysRw == sysWrite) begin
				memory[sysAddr] = sysWData;
			end else if (arstN && sysStrobe) begin
				base = sysAddr;
				for (int w = 0; w < 4; w++) begin
					waits = randomBits(2); // Zero to three wait cycles.
					repeat (waits) begin
						@(posedge clock);
						sysWordValid <= 1'b0;
					end
					@(posedge clock);
					sysWordValid <= 1'b1;
					sysRData     <= memory[base + w[`ADDR_W-1:0]];
				end
				@(posedge clock);
				sysWordValid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Processor requests
	////////////////////////////////////////

	task automatic request(input sysOp_t rw, input logic [`ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] data);
		int waited;
		if (!timedOut) begin
			pStrobe <= 1'b1;
			pRw     <= rw;
			pAddr   <= addr;
			pWData  <= data;
			@(posedge clock);
			pStrobe <= 1'b0;
			waited = 0;
			do begin
				@(negedge clock);
				waited++;
			end while (!cReady && waited < 200);
			if (!cReady) begin
				timedOut = 1'b1;
				check.fault($sformatf("cReady never rose for the request at address %h", addr));
			end
			@(posedge clock); // Next request starts on a rising edge.
		end
	endtask

	initial begin
		logic [31:0] pick;
		lfsr         = 32'h5184db39;
		timedOut     = 1'b0;
		arstN        = 1'b0;
		pStrobe      = 1'b0;
		pRw          = sysRead;
		pAddr        = '0;
		pWData       = '0;
		sysWordValid = 1'b0;
		sysRData     = '0;
		repeat (4) @(posedge clock);
		arstN <= 1'b1;

		check.startTest("cold read miss", 2);
		request(sysRead, 16'h0010, '0);
		check.endTest();

		check.startTest("read hit", 1);
		request(sysRead, 16'h0011, '0);
		request(sysRead, 16'h0012, '0);
		request(sysRead, 16'h0013, '0);
		check.endTest();

		check.startTest("write hit", 1);
		request(sysWrite, 16'h0012, 32'hcafe0012);
		request(sysRead, 16'h0012, '0);
		check.endTest();

		check.startTest("write miss", 0);
		request(sysWrite, 16'h0020, 32'hbeef0020);
		check.setMode(2); // The later read must fetch.
		request(sysRead, 16'h0020, '0);
		check.endTest();

		check.startTest("conflict", 2);
		request(sysRead, 16'h0110, '0); // Same index as 0x0010.
		request(sysRead, 16'h0010, '0);
		check.endTest();

		check.startTest("random mix", 0);
		for (int n = 0; n < 300; n++) begin
			pick = randomBits(1);
			if (pick[0]) begin
				pick = randomBits(8);
				request(sysWrite, {8'h00, pick[7:0]}, randomBits(32));
			end else begin
				pick = randomBits(8);
				request(sysRead, {8'h00, pick[7:0]}, '0);
			end
		end
		check.endTest();

		check.summarize();
		if (timedOut || check.errorCount != 0) begin
			$display("ERRORS FOUND");
		end else begin
			$display("NO ERRORS");
		end
		$finish;
	end

endmodule

/* testbench/cacheChecker.sv */
`include "cache_params.svh"

module cacheChecker import cachePkg::*; (
	input logic               clock,
	input logic               arstN,
	input logic               pStrobe,
	input sysOp_t             pRw,
	input logic [`ADDR_W-1:0] pAddr,
	input logic [`DATA_W-1:0] pWData,
	input logic [`DATA_W-1:0] pRData,
	input logic               cReady,
	input logic               sysStrobe,
	input sysOp_t             sysRw,
	input logic [`ADDR_W-1:0] sysAddr,
	input logic [`DATA_W-1:0] sysWData
);

	localparam int SHADOW_WORDS = 1024;

	logic [`DATA_W-1:0] shadow [SHADOW_WORDS];
	string              testName;
	int                 testErrors;
	int                 errorCount;
	int                 testCount;
	int                 passCount;
	int                 mode; // 0 any, 1 hit, 2 miss.
	logic               pending;
	sysOp_t             reqRw;
	logic [`ADDR_W-1:0] reqAddr;
	logic [`DATA_W-1:0] reqData;
	int                 cycles;
	int                 fetches;
	int                 writeStrobes;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [`DATA_W-1:0] fillWord(logic [`ADDR_W-1:0] addr);
		return {addr, addr ^ 16'h5a3c}; // Same pattern as the memory model.
	endfunction

	// Memory always holds the latest value under write-through.
	function automatic logic [`DATA_W-1:0] refRead(logic [`ADDR_W-1:0] addr);
		return shadow[addr[9:0]];
	endfunction

	initial begin
		for (int i = 0; i < SHADOW_WORDS; i++) begin
			shadow[i] = fillWord(i[`ADDR_W-1:0]);
		end
		errorCount = 0;
		testCount  = 0;
		passCount  = 0;
		testErrors = 0;
		mode       = 0;
		pending    = 1'b0;
		testName   = "reset";
	end

	////////////////////////////////////////
	// Test bookkeeping
	////////////////////////////////////////

	task automatic startTest(input string name, input int kind);
		testName   = name;
		testErrors = 0;
		mode       = kind;
	endtask

	task automatic setMode(input int kind);
		mode = kind;
	endtask

	task automatic endTest();
		testCount++;
		if (testErrors == 0) begin
			passCount++;
			$display("test %s passed", testName);
		end else begin
			$display("test %s failed with %0d errors", testName, testErrors);
		end
	endtask

	task automatic summarize();
		$display("%0d tests, %0d passed, %0d errors", testCount, passCount, errorCount);
	endtask

	task automatic mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		testErrors++;
		errorCount++;
		$display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
	endtask

	task automatic fault(input string text);
		testErrors++;
		errorCount++;
		$display("%s: %s", testName, text);
	endtask

	////////////////////////////////////////
	// Comparing process
	////////////////////////////////////////

	always @(negedge clock) begin
		if (arstN && pending) begin
			cycles++;
			if (sysStrobe && sysRw == sysWrite) begin
				writeStrobes++;
				if (sysAddr != reqAddr) mismatch("write address", 32'(reqAddr), 32'(sysAddr));
				if (sysWData != reqData) mismatch("write data", reqData, sysWData);
			end else if (sysStrobe) begin
				fetches++;
				if (reqRw == sysWrite) fault("a line fetch was issued for a write");
				if (sysAddr != {reqAddr[`ADDR_W-1:2], 2'b00}) begin
					mismatch("fetch address", 32'({reqAddr[`ADDR_W-1:2], 2'b00}), 32'(sysAddr));
				end
			end
			if (cReady) begin
				pending = 1'b0;
				if (reqRw == sysRead) begin
					if (pRData != refRead(reqAddr)) mismatch("read data", refRead(reqAddr), pRData);
					if (mode == 1 && (cycles != 1 || fetches != 0)) fault("read did not hit");
					if (mode == 2 && fetches != 1) fault("read did not fetch exactly one line");
				end else begin
					shadow[reqAddr[9:0]] = reqData;
					if (cycles != 1) fault("write ready was not one cycle after the strobe");
					if (writeStrobes != 1) fault("write did not reach memory exactly once");
				end
			end
		end else if (arstN && sysStrobe) begin
			fault("system strobe with no request in flight");
		end
		if (arstN && pStrobe) begin
			pending      = 1'b1;
			reqRw        = pRw;
			reqAddr      = pAddr;
			reqData      = pWData;
			cycles       = 0;
			fetches      = 0;
			writeStrobes = 0;
		end
	end

endmodule

/* design/cacheTop.sv */
`include "cache_params.svh"

module cacheTop import cachePkg::*; (
	input  logic               clock,
	input  logic               arstN,
	input  logic               pStrobe,
	input  sysOp_t             pRw,
	input  logic [`ADDR_W-1:0] pAddr,
	input  logic [`DATA_W-1:0] pWData,
	output logic [`DATA_W-1:0] pRData,
	output logic               cReady,
	output logic               sysStrobe,
	output sysOp_t             sysRw,
	output logic [`ADDR_W-1:0] sysAddr,
	output logic [`DATA_W-1:0] sysWData,
	input  logic               sysWordValid,
	input  logic [`DATA_W-1:0] sysRData
);

	logic [`ADDR_W-1:0] reqAddr;
	logic [`DATA_W-1:0] reqWData;

	cacheLookupIf lookup ();
	cacheFillIf   fill ();

	////////////////////////////////////////
	// Request register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (pStrobe) begin
			reqAddr  <= pAddr;
			reqWData <= pWData; // Held for the write-through cycle.
		end
	end

	// Fetches always start at the line base.
	assign sysAddr  = (sysRw == sysWrite) ? reqAddr : {reqAddr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
	assign sysWData = reqWData;

	////////////////////////////////////////
	// Blocks
	////////////////////////////////////////

	cacheTagStore tagStore (
		.clock   (clock),
		.arstN   (arstN),
		.reqAddr (reqAddr),
		.lookup  (lookup.tag)
	);

	cacheController controller (
		.clock     (clock),
		.arstN     (arstN),
		.pStrobe   (pStrobe),
		.pRw       (pRw),
		.lookup    (lookup.ctrl),
		.fill      (fill.ctrl),
		.cReady    (cReady),
		.sysStrobe (sysStrobe),
		.sysRw     (sysRw)
	);

	cacheDataStore dataStore (
		.clock        (clock),
		.arstN        (arstN),
		.reqAddr      (reqAddr),
		.pWData       (reqWData),
		.sysWordValid (sysWordValid),
		.sysRData     (sysRData),
		.fill         (fill.data),
		.pRData       (pRData)
	);

endmodule

/* design/cacheDataStore.sv */
`include "cache_params.svh"

module cacheDataStore import cachePkg::*; (
	input  logic               clock,
	input  logic               arstN,
	input  logic [`ADDR_W-1:0] reqAddr,
	input  logic [`DATA_W-1:0] pWData,
	input  logic               sysWordValid,
	input  logic [`DATA_W-1:0] sysRData,
	cacheFillIf.data           fill,
	output logic [`DATA_W-1:0] pRData
);

	logic [`OFFSET_W-1:0]          fillCount;
	logic                          takeWord;
	logic                          writeEnable;
	logic [`INDEX_W+`OFFSET_W-1:0] reqSlot;
	logic [`INDEX_W+`OFFSET_W-1:0] writeSlot;
	logic [`DATA_W-1:0]            writeData;
	logic [`DATA_W-1:0]            dataArray [`WORDS];

	assign reqSlot  = reqAddr[`INDEX_W+`OFFSET_W-1:0]; // Index and offset.
	assign takeWord = fill.write && fill.dataSource == srcSys && sysWordValid;

	////////////////////////////////////////
	// Fill counter
	////////////////////////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			fillCount <= '0;
		end else if (fill.flush) begin
			fillCount <= '0;
		end else if (takeWord) begin
			fillCount <= fillCount + 1'b1;
		end
	end

	assign fill.lineDone = takeWord && fillCount == '1; // Fourth word.

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_comb begin
		if (fill.dataSource == srcSys) begin
			writeEnable = takeWord;
			writeSlot   = {reqSlot[`INDEX_W+`OFFSET_W-1:`OFFSET_W], fillCount};
			writeData   = sysRData;
		end else begin
			writeEnable = fill.write;
			writeSlot   = reqSlot;
			writeData   = pWData;
		end
	end

	always_ff @(posedge clock) begin
		if (writeEnable) begin
			dataArray[writeSlot] <= writeData;
		end
	end

	// Read port is combinational so a hit answers in the lookup cycle.
	assign pRData = dataArray[reqSlot];

	////////////////////////////////////////
	// Assertions
	////////////////////////////////////////

	wordOnlyDuringFill: assert property (
		@(posedge clock) disable iff (!arstN)
		sysWordValid |-> fill.write && fill.dataSource == srcSys
	) else $error("Memory word arrived outside a line fill.");

endmodule

/* design/cacheController.sv */
module cacheController import cachePkg::*; (
	input  logic   clock,
	input  logic   arstN,
	input  logic   pStrobe,
	input  sysOp_t pRw,
	cacheLookupIf.ctrl lookup,
	cacheFillIf.ctrl   fill,
	output logic   cReady,
	output logic   sysStrobe,
	output sysOp_t sysRw
);

	cacheState_t state;
	cacheState_t nextState;
	cacheState_t acceptState;
	logic        hit;

	assign hit = lookup.tagMatch && lookup.valid;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	// Target state when a new request can be taken this cycle.
	always_comb begin
		if (!pStrobe) begin
			acceptState = idle;
		end else if (pRw == sysRead) begin
			acceptState = read;
		end else begin
			acceptState = write;
		end
	end

	always_comb begin
		case (state)
			idle: begin
				nextState = acceptState;
			end
			read: begin
				if (hit) begin
					nextState = acceptState; // Hit answers now.
				end else begin
					nextState = readMiss;
				end
			end
			readMiss: begin
				nextState = readSys;
			end
			readSys: begin
				if (fill.lineDone) begin
					nextState = readData;
				end else begin
					nextState = readSys; // Memory wait cycles.
				end
			end
			readData: begin
				nextState = acceptState;
			end
			write: begin
				nextState = acceptState;
			end
			default: begin
				nextState = idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	always_comb begin
		cReady          = 1'b0;
		sysStrobe       = 1'b0;
		sysRw           = sysRead;
		lookup.fillTag  = 1'b0;
		fill.write      = 1'b0;
		fill.dataSource = srcProc;
		fill.flush      = 1'b0;
		case (state)
			idle: begin
				cReady = 1'b1;
			end
			read: begin
				cReady = hit;
			end
			readMiss: begin
				sysStrobe      = 1'b1; // Fetch the whole line.
				sysRw          = sysRead;
				lookup.fillTag = 1'b1;
				fill.flush     = 1'b1;
			end
			readSys: begin
				fill.write      = 1'b1;
				fill.dataSource = srcSys;
			end
			readData: begin
				cReady = 1'b1;
			end
			write: begin
				cReady     = 1'b1;
				sysStrobe  = 1'b1; // Write-through, no allocate.
				sysRw      = sysWrite;
				fill.write = hit;
			end
			default: begin
			end
		endcase
	end

	////////////////////////////////////////
	// Assertions
	////////////////////////////////////////

	noStrobeInFill: assert property (
		@(posedge clock) disable iff (!arstN)
		state == readSys |-> !sysStrobe
	) else $error("System strobe during a line fill.");

	readyNotWithFetch: assert property (
		@(posedge clock) disable iff (!arstN)
		!(cReady && sysStrobe && sysRw == sysRead)
	) else $error("Ready raised together with a line fetch.");

	stateKnown: assert property (
		@(posedge clock) disable iff (!arstN)
		!$isunknown(state)
	) else $error("Controller state is unknown.");

endmodule

/* design/cacheTagStore.sv */
`include "cache_params.svh"

module cacheTagStore (
	input  logic               clock,
	input  logic               arstN,
	input  logic [`ADDR_W-1:0] reqAddr,
	cacheLookupIf.tag          lookup
);

	logic [`INDEX_W-1:0] index;
	logic [`TAG_W-1:0]   reqTag;
	logic [`LINES-1:0]   validBits;
	logic [`TAG_W-1:0]   tagArray [`LINES];

	////////////////////////////////////////
	// Address split
	////////////////////////////////////////

	assign index  = reqAddr[`OFFSET_W +: `INDEX_W];
	assign reqTag = reqAddr[`ADDR_W-1 -: `TAG_W];

	////////////////////////////////////////
	// Valid bits and tags
	////////////////////////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			validBits <= '0; // Cold cache.
		end else if (lookup.fillTag) begin
			validBits[index] <= 1'b1;
		end
	end

	// Tag is written at the start of a refill; the data follows over the next cycles.
	always_ff @(posedge clock) begin
		if (lookup.fillTag) begin
			tagArray[index] <= reqTag;
		end
	end

	////////////////////////////////////////
	// Hit detection
	////////////////////////////////////////

	assign lookup.tagMatch = tagArray[index] == reqTag;
	assign lookup.valid    = validBits[index];

	////////////////////////////////////////
	// Assertions
	////////////////////////////////////////

	// A refill is only started for a line that missed.
	fillOnlyOnMiss: assert property (
		@(posedge clock) disable iff (!arstN)
		lookup.fillTag |-> !(lookup.tagMatch && lookup.valid)
	) else $error("Tag fill on a line that already hits.");

endmodule

/* design/cacheIfs.sv */
interface cacheLookupIf;

	logic tagMatch; // Stored tag equals the request tag.
	logic valid;    // Indexed line holds data.
	logic fillTag;  // Claim the indexed line for the request.

	modport tag (
		output tagMatch,
		output valid,
		input  fillTag
	);

	modport ctrl (
		input  tagMatch,
		input  valid,
		output fillTag
	);

endinterface

interface cacheFillIf import cachePkg::*; ();

	logic        write;      // Store a word this cycle.
	dataSource_t dataSource;
	logic        flush;      // Restart the fill counter.
	logic        lineDone;   // Last fill word taken.

	modport ctrl (
		output write,
		output dataSource,
		output flush,
		input  lineDone
	);

	modport data (
		input  write,
		input  dataSource,
		input  flush,
		output lineDone
	);

endinterface

/* design/cachePkg.sv */
package cachePkg;

	////////////////////////////////////////
	// Controller states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		idle,     // Waiting for a request.
		read,     // Lookup of a read request.
		readMiss, // Line fetch is requested.
		readSys,  // Fill words arriving.
		readData, // Refilled word goes out.
		write     // Write-through to memory.
	} cacheState_t;

	////////////////////////////////////////
	// System bus and fill source
	////////////////////////////////////////

	typedef enum logic {
		sysRead,
		sysWrite
	} sysOp_t;

	typedef enum logic {
		srcProc, // Processor write data.
		srcSys   // Word from system memory.
	} dataSource_t;

endpackage

/* design/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

////////////////////////////////////////
// Word and address widths
////////////////////////////////////////

`define ADDR_W   16 // Word address, not byte address.
`define DATA_W   32

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

`define OFFSET_W 2  // Four words per line.
`define INDEX_W  4  // Sixteen lines.
`define TAG_W    (`ADDR_W - `INDEX_W - `OFFSET_W)
`define LINES    (1 << `INDEX_W)
`define WORDS    (1 << (`INDEX_W + `OFFSET_W))

`endif
